/* logic/core_pkg.sv */
`default_nettype none

package core_pkg;

    // operand and result data
    typedef logic [31:0] word_t;

    // instruction address
    typedef logic [31:0] pc_t;

    // physical register tag
    typedef logic [7:0] preg_t;

    // divide unit opcode
    typedef logic [3:0] div_op_t;

endpackage

`default_nettype wire

/* logic/rs_pkg.sv */
`default_nettype none

package rs_pkg;

    // entries in the divide station unless the top overrides it
    parameter int DEFAULT_DEPTH = 16;

    // result buses snooped for wakeup: alu, mul, div, load
    parameter int BROADCASTS = 4;

endpackage

`default_nettype wire

/* logic/operand_capture.sv */
`default_nettype none

module operand_capture (
    input  wire core_pkg::preg_t tag,
    input  wire core_pkg::word_t data,
    input  wire                  ready,
    input  wire                  alu_valid,
    input  wire core_pkg::preg_t alu_dest,
    input  wire core_pkg::word_t alu_result,
    input  wire                  mul_valid,
    input  wire core_pkg::preg_t mul_dest,
    input  wire core_pkg::word_t mul_result,
    input  wire                  div_valid,
    input  wire core_pkg::preg_t div_dest,
    input  wire core_pkg::word_t div_result,
    input  wire                  load_valid,
    input  wire core_pkg::preg_t load_dest,
    input  wire core_pkg::word_t load_data,
    output core_pkg::word_t      out_data,
    output logic                 out_ready
);

    logic [rs_pkg::BROADCASTS-1:0] hit;             // bit 0 is highest priority
    core_pkg::word_t bus_data [rs_pkg::BROADCASTS];

    assign hit = {load_valid && (load_dest == tag),
                  div_valid && (div_dest == tag),
                  mul_valid && (mul_dest == tag),
                  alu_valid && (alu_dest == tag)};

    assign bus_data[0] = alu_result;
    assign bus_data[1] = mul_result;
    assign bus_data[2] = div_result;
    assign bus_data[3] = load_data;

    always_comb begin
        out_data  = data;
        out_ready = ready;
        if (!ready) begin
            // walk down so the alu bus overrides the others
            for (int i = rs_pkg::BROADCASTS - 1; i >= 0; i--) begin
                if (hit[i]) begin
                    out_data  = bus_data[i];
                    out_ready = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/age_select.sv */
`default_nettype none

module age_select #(
    parameter  int DEPTH = rs_pkg::DEFAULT_DEPTH,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  wire [DEPTH-1:0] ready_vec,
    input  wire [IDX_W-1:0] head_idx,
    output logic            pick_valid,
    output logic [IDX_W-1:0] pick_idx
);

    typedef logic [IDX_W-1:0] idx_t;

    // circular scan from head, nearest hit wins
    always_comb begin
        idx_t idx;
        pick_valid = 1'b0;
        pick_idx   = head_idx;
        for (int k = DEPTH - 1; k >= 0; k--) begin
            idx = head_idx + IDX_W'(k);  // wraps, depth is a power of two
            if (ready_vec[idx]) begin
                pick_valid = 1'b1;
                pick_idx   = idx;
            end
        end
    end

    // nothing ready must mean no pick, and a pick must land on a ready entry
    always_comb begin
        assert final ((pick_valid == (|ready_vec)) && (!pick_valid || ready_vec[pick_idx]))
        else $error("age_select: pick %0d not ready, vec %h", pick_idx, ready_vec);
    end

endmodule

`default_nettype wire

/* logic/rs_entry_array.sv */
`default_nettype none

module rs_entry_array #(
    parameter  int DEPTH = rs_pkg::DEFAULT_DEPTH,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    disp_valid,
    input  wire core_pkg::pc_t     disp_pc,
    input  wire core_pkg::preg_t   disp_rd,
    input  wire core_pkg::div_op_t disp_op,
    input  wire core_pkg::preg_t   disp_src1_tag,
    input  wire core_pkg::word_t   disp_src1_data,
    input  wire                    disp_src1_ready,
    input  wire core_pkg::preg_t   disp_src2_tag,
    input  wire core_pkg::word_t   disp_src2_data,
    input  wire                    disp_src2_ready,
    input  wire                    alu_valid,
    input  wire core_pkg::preg_t   alu_dest,
    input  wire core_pkg::word_t   alu_result,
    input  wire                    mul_valid,
    input  wire core_pkg::preg_t   mul_dest,
    input  wire core_pkg::word_t   mul_result,
    input  wire                    div_valid,
    input  wire core_pkg::preg_t   div_dest,
    input  wire core_pkg::word_t   div_result,
    input  wire                    load_valid,
    input  wire core_pkg::preg_t   load_dest,
    input  wire core_pkg::word_t   load_data,
    input  wire                    pick_valid,
    input  wire [IDX_W-1:0]        pick_idx,
    output logic [DEPTH-1:0]       ready_vec,
    output logic [IDX_W-1:0]       head_idx,
    output logic                   issue_valid,
    output core_pkg::pc_t          issue_pc,
    output core_pkg::preg_t        issue_rd,
    output core_pkg::div_op_t      issue_op,
    output core_pkg::word_t        issue_src1,
    output core_pkg::word_t        issue_src2
);

    typedef logic [IDX_W-1:0] idx_t;

    idx_t             tail;
    logic [DEPTH-1:0] busy;
    logic [DEPTH-1:0] src1_rdy_q;
    logic [DEPTH-1:0] src2_rdy_q;

    core_pkg::pc_t     pc_q       [DEPTH];
    core_pkg::preg_t   rd_q       [DEPTH];
    core_pkg::div_op_t op_q       [DEPTH];
    core_pkg::preg_t   src1_tag_q [DEPTH];
    core_pkg::preg_t   src2_tag_q [DEPTH];
    core_pkg::word_t   src1_data_q [DEPTH];
    core_pkg::word_t   src2_data_q [DEPTH];

    // operands after this cycle's broadcasts
    core_pkg::word_t   src1_wake_data [DEPTH];
    core_pkg::word_t   src2_wake_data [DEPTH];
    logic [DEPTH-1:0]  src1_wake_rdy;
    logic [DEPTH-1:0]  src2_wake_rdy;

    core_pkg::word_t   disp1_data;
    core_pkg::word_t   disp2_data;
    logic              disp1_ready;
    logic              disp2_ready;

    // forwarding for the incoming instruction
    operand_capture i_disp_src1 (
        .tag(disp_src1_tag), .data(disp_src1_data), .ready(disp_src1_ready),
        .out_data(disp1_data), .out_ready(disp1_ready), .*
    );

    operand_capture i_disp_src2 (
        .tag(disp_src2_tag), .data(disp_src2_data), .ready(disp_src2_ready),
        .out_data(disp2_data), .out_ready(disp2_ready), .*
    );

    for (genvar g = 0; g < DEPTH; g++) begin : g_entry
        operand_capture i_src1 (
            .tag(src1_tag_q[g]), .data(src1_data_q[g]), .ready(src1_rdy_q[g]),
            .out_data(src1_wake_data[g]), .out_ready(src1_wake_rdy[g]), .*
        );

        operand_capture i_src2 (
            .tag(src2_tag_q[g]), .data(src2_data_q[g]), .ready(src2_rdy_q[g]),
            .out_data(src2_wake_data[g]), .out_ready(src2_wake_rdy[g]), .*
        );
    end

    assign ready_vec = busy & src1_rdy_q & src2_rdy_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy        <= '0;
            src1_rdy_q  <= '0;
            src2_rdy_q  <= '0;
            tail        <= '0;
            head_idx    <= '0;
            issue_valid <= 1'b0;
        end else begin
            src1_rdy_q  <= src1_wake_rdy;
            src2_rdy_q  <= src2_wake_rdy;
            issue_valid <= pick_valid;
            if (pick_valid) begin
                busy[pick_idx] <= 1'b0;
            end
            if (disp_valid) begin
                busy[tail]       <= 1'b1;
                src1_rdy_q[tail] <= disp1_ready;
                src2_rdy_q[tail] <= disp2_ready;
                tail             <= tail + 1'b1;
            end
            // head == tail with live entries means a full window, so still step
            if (!busy[head_idx] && ((head_idx != tail) || (|busy))) begin
                head_idx <= head_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            src1_data_q[i] <= src1_wake_data[i];
            src2_data_q[i] <= src2_wake_data[i];
        end
        if (disp_valid) begin
            pc_q[tail]        <= disp_pc;
            rd_q[tail]        <= disp_rd;
            op_q[tail]        <= disp_op;
            src1_tag_q[tail]  <= disp_src1_tag;
            src2_tag_q[tail]  <= disp_src2_tag;
            src1_data_q[tail] <= disp1_data;
            src2_data_q[tail] <= disp2_data;
        end
        if (pick_valid) begin  // fields hold between issues
            issue_pc   <= pc_q[pick_idx];
            issue_rd   <= rd_q[pick_idx];
            issue_op   <= op_q[pick_idx];
            issue_src1 <= src1_data_q[pick_idx];
            issue_src2 <= src2_data_q[pick_idx];
        end
    end

    a_disp_free: assert property (@(posedge clk) disable iff (reset)
        disp_valid |-> !busy[tail])
        else $error("rs_entry_array: dispatch into busy slot %0d", tail);

    // every issue strobe traces back to a pick of a live entry
    a_issue_from_pick: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> $past(pick_valid && busy[pick_idx]))
        else $error("rs_entry_array: issue without a valid pick");

endmodule

`default_nettype wire

/* logic/rs_div.sv */
`default_nettype none

module rs_div #(
    parameter int DEPTH = rs_pkg::DEFAULT_DEPTH
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    disp_valid,
    input  wire core_pkg::pc_t     disp_pc,
    input  wire core_pkg::preg_t   disp_rd,
    input  wire core_pkg::div_op_t disp_op,
    input  wire core_pkg::preg_t   disp_src1_tag,
    input  wire core_pkg::word_t   disp_src1_data,
    input  wire                    disp_src1_ready,
    input  wire core_pkg::preg_t   disp_src2_tag,
    input  wire core_pkg::word_t   disp_src2_data,
    input  wire                    disp_src2_ready,
    input  wire                    alu_valid,
    input  wire core_pkg::preg_t   alu_dest,
    input  wire core_pkg::word_t   alu_result,
    input  wire                    mul_valid,
    input  wire core_pkg::preg_t   mul_dest,
    input  wire core_pkg::word_t   mul_result,
    input  wire                    div_valid,
    input  wire core_pkg::preg_t   div_dest,
    input  wire core_pkg::word_t   div_result,
    input  wire                    load_valid,
    input  wire core_pkg::preg_t   load_dest,
    input  wire core_pkg::word_t   load_data,
    output wire                    issue_valid,
    output wire core_pkg::pc_t     issue_pc,
    output wire core_pkg::preg_t   issue_rd,
    output wire core_pkg::div_op_t issue_op,
    output wire core_pkg::word_t   issue_src1,
    output wire core_pkg::word_t   issue_src2
);

    localparam int IDX_W = $clog2(DEPTH);

    wire [DEPTH-1:0] ready_vec;   // both operands in, entry live
    wire [IDX_W-1:0] head_idx;
    wire             pick_valid;
    wire [IDX_W-1:0] pick_idx;

    rs_entry_array #(
        .DEPTH(DEPTH)
    ) i_entries (
        .clk(clk), .reset(reset),
        .disp_valid(disp_valid), .disp_pc(disp_pc), .disp_rd(disp_rd), .disp_op(disp_op),
        .disp_src1_tag(disp_src1_tag), .disp_src1_data(disp_src1_data),
        .disp_src1_ready(disp_src1_ready),
        .disp_src2_tag(disp_src2_tag), .disp_src2_data(disp_src2_data),
        .disp_src2_ready(disp_src2_ready),
        .alu_valid(alu_valid), .alu_dest(alu_dest), .alu_result(alu_result),
        .mul_valid(mul_valid), .mul_dest(mul_dest), .mul_result(mul_result),
        .div_valid(div_valid), .div_dest(div_dest), .div_result(div_result),
        .load_valid(load_valid), .load_dest(load_dest), .load_data(load_data),
        .pick_valid(pick_valid), .pick_idx(pick_idx),
        .ready_vec(ready_vec), .head_idx(head_idx),
        .issue_valid(issue_valid), .issue_pc(issue_pc), .issue_rd(issue_rd),
        .issue_op(issue_op), .issue_src1(issue_src1), .issue_src2(issue_src2)
    );

    age_select #(
        .DEPTH(DEPTH)
    ) i_select (
        .ready_vec(ready_vec),
        .head_idx(head_idx),
        .pick_valid(pick_valid),
        .pick_idx(pick_idx)
    );

endmodule

`default_nettype wire

/* verif/rs_div_tb.sv */
`default_nettype none

module rs_div_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = 4;
    localparam int NUM_COLS = 28;
    localparam int MAX_CYCLES = 200;
    localparam int RESET_WAIT = 20;

    logic                   clk;
    logic                   reset;
    logic                   disp_valid;
    core_pkg::pc_t          disp_pc;
    core_pkg::preg_t        disp_rd;
    core_pkg::div_op_t      disp_op;
    core_pkg::preg_t        disp_src1_tag;
    core_pkg::word_t        disp_src1_data;
    logic                   disp_src1_ready;
    core_pkg::preg_t        disp_src2_tag;
    core_pkg::word_t        disp_src2_data;
    logic                   disp_src2_ready;
    logic                   alu_valid;
    core_pkg::preg_t        alu_dest;
    core_pkg::word_t        alu_result;
    logic                   mul_valid;
    core_pkg::preg_t        mul_dest;
    core_pkg::word_t        mul_result;
    logic                   div_valid;
    core_pkg::preg_t        div_dest;
    core_pkg::word_t        div_result;
    logic                   load_valid;
    core_pkg::preg_t        load_dest;
    core_pkg::word_t        load_data;
    wire                    issue_valid;
    wire core_pkg::pc_t     issue_pc;
    wire core_pkg::preg_t   issue_rd;
    wire core_pkg::div_op_t issue_op;
    wire core_pkg::word_t   issue_src1;
    wire core_pkg::word_t   issue_src2;

    int          errors;
    int          checks;
    int          cycle;
    logic [31:0] col [NUM_COLS];
    logic [31:0] held [5];   // last issued pc rd op src1 src2
    logic        have_held;

    rs_div #(
        .DEPTH(DEPTH)
    ) i_dut (
        .clk(clk), .reset(reset),
        .disp_valid(disp_valid), .disp_pc(disp_pc), .disp_rd(disp_rd), .disp_op(disp_op),
        .disp_src1_tag(disp_src1_tag), .disp_src1_data(disp_src1_data),
        .disp_src1_ready(disp_src1_ready),
        .disp_src2_tag(disp_src2_tag), .disp_src2_data(disp_src2_data),
        .disp_src2_ready(disp_src2_ready),
        .alu_valid(alu_valid), .alu_dest(alu_dest), .alu_result(alu_result),
        .mul_valid(mul_valid), .mul_dest(mul_dest), .mul_result(mul_result),
        .div_valid(div_valid), .div_dest(div_dest), .div_result(div_result),
        .load_valid(load_valid), .load_dest(load_dest), .load_data(load_data),
        .issue_valid(issue_valid), .issue_pc(issue_pc), .issue_rd(issue_rd),
        .issue_op(issue_op), .issue_src1(issue_src1), .issue_src2(issue_src2)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h (cycle %0d)", name, got, exp, cycle);
        end
    endtask

    // one stimulus row into col, returns the number of fields read
    function automatic int parse_row(input string text);
        return $sscanf(text,
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
            col[8], col[9], col[10], col[11], col[12], col[13], col[14],
            col[15], col[16], col[17], col[18], col[19], col[20], col[21],
            col[22], col[23], col[24], col[25], col[26], col[27]);
    endfunction

    // column order matches the stim file header
    task automatic drive_columns();
        disp_valid      <= col[0][0];
        disp_pc         <= col[1];
        disp_rd         <= core_pkg::preg_t'(col[2]);
        disp_op         <= core_pkg::div_op_t'(col[3]);
        disp_src1_tag   <= core_pkg::preg_t'(col[4]);
        disp_src1_data  <= col[5];
        disp_src1_ready <= col[6][0];
        disp_src2_tag   <= core_pkg::preg_t'(col[7]);
        disp_src2_data  <= col[8];
        disp_src2_ready <= col[9][0];
        alu_valid       <= col[10][0];
        alu_dest        <= core_pkg::preg_t'(col[11]);
        alu_result      <= col[12];
        mul_valid       <= col[13][0];
        mul_dest        <= core_pkg::preg_t'(col[14]);
        mul_result      <= col[15];
        div_valid       <= col[16][0];
        div_dest        <= core_pkg::preg_t'(col[17]);
        div_result      <= col[18];
        load_valid      <= col[19][0];
        load_dest       <= core_pkg::preg_t'(col[20]);
        load_data       <= col[21];
    endtask

    // issue fields keep the last strobe's values in idle cycles
    task automatic check_issue();
        compare_value("issue_valid", 32'(issue_valid), col[22]);
        if (col[22][0]) begin
            for (int i = 0; i < 5; i++) begin
                held[i] = col[23 + i];
            end
            have_held = 1'b1;
        end
        if (have_held) begin
            compare_value("issue_pc", issue_pc, held[0]);
            compare_value("issue_rd", 32'(issue_rd), held[1]);
            compare_value("issue_op", 32'(issue_op), held[2]);
            compare_value("issue_src1", issue_src1, held[3]);
            compare_value("issue_src2", issue_src2, held[4]);
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    wait_cnt;
        string line;
        errors    = 0;
        checks    = 0;
        cycle     = 0;
        have_held = 1'b0;
        for (int i = 0; i < NUM_COLS; i++) begin
            col[i] = '0;
        end
        drive_columns();
        wait_cnt = 0;
        while (reset && wait_cnt < RESET_WAIT) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (reset) begin
            errors++;
            $display("reset was never released");
        end else begin
            fd = $fopen("verif/rs_div_stim.txt", "r");
            if (fd == 0) begin
                errors++;
                $display("could not open the stimulus file");
            end else begin
                while (!$feof(fd) && cycle < MAX_CYCLES) begin
                    line = "";
                    n = $fgets(line, fd);
                    if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
                        continue;
                    end
                    n = parse_row(line);
                    if (n != NUM_COLS) begin
                        errors++;
                        $display("stimulus line %0d has %0d fields, not %0d", cycle, n,
                                 NUM_COLS);
                        continue;
                    end
                    @(posedge clk);
                    drive_columns();
                    @(negedge clk);
                    check_issue();
                    cycle++;
                end
                if (!$feof(fd)) begin
                    errors++;
                    $display("stimulus did not end within %0d cycles", MAX_CYCLES);
                end
                $fclose(fd);
            end
        end
        $display("errors: %0d of %0d checks over %0d cycles", errors, checks, cycle);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/rs_div_stim.txt */
# dv pc rd op t1 d1 r1 t2 d2 r2 | alu v d r | mul v d r | div v d r | load v d r
# then expected: issue_valid pc rd op src1 src2 (checked in the same line's cycle)
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 100 21 1 0 aa 1 0 bb 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 100 21 1 aa bb
1 104 22 2 30 0 0 0 cc 1 1 30 1234 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 108 23 3 31 0 0 0 dd 1 0 0 0 0 31 dead 0 0 0 0 0 0 0 0 0 0 0 0
1 10c 24 4 0 11 1 32 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 104 22 2 1234 cc
1 110 25 5 33 0 0 34 0 0 0 0 0 0 0 0 0 0 0 1 31 4444 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 1 32 5555 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 33 6666 0 0 0 1 108 23 3 4444 dd
0 0 0 0 0 0 0 0 0 0 1 34 7777 0 0 0 0 0 0 1 34 8888 1 10c 24 4 11 5555
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 110 25 5 6666 7777
1 200 31 6 40 0 0 0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 204 32 7 0 2 1 40 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 208 33 8 40 0 0 40 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 40 9999 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 200 31 6 9999 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 204 32 7 2 9999
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 208 33 8 9999 9999
1 300 41 9 0 3 1 0 4 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 304 42 a 0 5 1 0 6 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 300 41 9 3 4
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 304 42 a 5 6
1 400 51 b 50 0 0 0 7 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 404 52 c 50 0 0 0 8 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 408 53 d 50 0 0 0 9 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 40c 54 e 50 0 0 0 a 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 50 abcd 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 400 51 b abcd 7
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 404 52 c abcd 8
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 408 53 d abcd 9
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 40c 54 e abcd a
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

/* all.f */
logic/core_pkg.sv
logic/rs_pkg.sv
logic/operand_capture.sv
logic/age_select.sv
logic/rs_entry_array.sv
logic/rs_div.sv
verif/rs_div_tb.sv

/* run.sh */
#!/bin/sh
# build and run the reservation station testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module rs_div_tb \
    -o rs_div_sim > build.log 2>&1 \
    && ./obj_dir/rs_div_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; } \
    || grep -q "TESTBENCH PASSED" sim.log \
    || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
